// ==== Makefile ====
# Verilator build and run of the delay generator testbench

VERILATOR ?= verilator
TOP       ?= tb_delay_generator
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= >>> FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo '$(FAIL_MSG)' >> $(LOG)
	@cat $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation finished without failure"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/delay_generator_top.sv ====
// ======================================================================
// delay generator top level
// host setpoint registers, pulse core and trigger output stage
// ======================================================================

`timescale 1ns/1ps

module delay_generator_top
   import dg_pkg::*;
(
   input  logic                   clk100,
   input  logic                   hps_fpga_reset_n,
   input  host_write_t            host,
   output logic [NDELAY_PINS-1:0] trig_pins,
   output logic                   t0,
   output t0_event_t              t0_event
);

   logic [CNT_W-1:0]        interval;             // active interval
   channel_set_t            channels;             // committed pairs
   logic [PROTO_W-1:0]      protocol;
   logic                    t0_raw;               // core t0, one stage early
   logic [NDELAY_PAIRS-1:0] pulses;               // raw channel windows

   setpoint_regs u_regs (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .host             (host),
      .interval         (interval),
      .channels         (channels),
      .protocol         (protocol)
   );

   delay_pulse_core u_core (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .interval         (interval),
      .channels         (channels),
      .t0_raw           (t0_raw),
      .pulses           (pulses)
   );

   trigger_out_stage u_out (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .t0_raw           (t0_raw),
      .pulses           (pulses),
      .protocol         (protocol),
      .trig_pins        (trig_pins),
      .t0               (t0),
      .t0_event         (t0_event)
   );

endmodule

// ==== logic/delay_pulse_core.sv ====
// ======================================================================
// delay pulse core
// free-running period counter with wrap on the active interval,
// registered t0 marker and the bank of delay/width channels
// ======================================================================

`timescale 1ns/1ps

module delay_pulse_core
   import dg_pkg::*;
(
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,
   input  logic [CNT_W-1:0]        interval,      // cycles per period, >= floor
   input  channel_set_t            channels,      // committed pairs
   output logic                    t0_raw,        // one cycle per period
   output logic [NDELAY_PAIRS-1:0] pulses         // per-channel windows
);

   logic [CNT_W-1:0] count;                       // 0 .. interval-1
   logic [CNT_W-1:0] last_count;                  // interval-1
   logic             wrap;

   // ===================================================================
   // period counter
   // ===================================================================
   assign last_count = interval - 1'b1;
   assign wrap       = (count >= last_count);     // also catches a shrunk interval

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         count <= '0;
      end else if (wrap) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // t0 registered like the channel pulses, same latency
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         t0_raw <= 1'b0;
      end else begin
         t0_raw <= (count == '0);
      end
   end

   // ===================================================================
   // channel bank
   // ===================================================================
   for (genvar k = 0; k < NDELAY_PAIRS; k++) begin : g_chan
      pulse_channel u_chan (
         .clk100           (clk100),
         .hps_fpga_reset_n (hps_fpga_reset_n),
         .count            (count),
         .setting          (channels[k]),
         .pulse            (pulses[k])
      );
   end

endmodule

// ==== logic/dg_pkg.sv ====
// ======================================================================
// delay generator shared definitions
// sizes, register map and interval limits
// packed structs for host writes, channel pairs and t0 event records
// ======================================================================

package dg_pkg;

   // ===================================================================
   // sizes
   // ===================================================================
   localparam int NDELAY_PAIRS = 9;                 // delay/width channels
   localparam int NDELAY_PINS  = 7;                 // physical trigger pins
   localparam int CNT_W        = 32;                // delay, width, interval, count
   localparam int TS_W         = 64;                // clk100 cycle timestamp
   localparam int PROTO_W      = 2;                 // protocol number
   localparam int HOST_DATA_W  = 2 * CNT_W;         // one 64-bit register word
   localparam int COMMIT_BIT   = 32;                // commit flag in ctrl word

   // interval limits, 10 ns per cycle
   localparam logic [CNT_W-1:0] INTERVAL_MIN   = 32'd1000;    // 10 us floor
   localparam logic [CNT_W-1:0] INTERVAL_RESET = 32'd100000;  // 1 ms default

   // ===================================================================
   // host register map
   // ===================================================================
   localparam int                ADDR_W     = 4;
   localparam logic [ADDR_W-1:0] ADDR_CTRL  = 4'd1;   // interval + commit flag
   localparam logic [ADDR_W-1:0] ADDR_PAIR0 = 4'd2;   // pairs 0..8 at 2..10
   localparam logic [ADDR_W-1:0] ADDR_PROTO = 4'd15;  // protocol number

   typedef struct packed {
      logic [CNT_W-1:0] delay;                      // data bits 63..32
      logic [CNT_W-1:0] width;                      // data bits 31..0
   } delay_width_t;

   typedef struct packed {
      logic                   wr;                   // one-cycle write strobe
      logic [ADDR_W-1:0]      addr;                 // register select
      logic [HOST_DATA_W-1:0] data;
   } host_write_t;

   typedef delay_width_t [NDELAY_PAIRS-1:0] channel_set_t;  // committed pair set

   typedef struct packed {
      logic               valid;                    // high with t0
      logic [TS_W-1:0]    timestamp;                // cycles since reset release
      logic [PROTO_W-1:0] protocol;
   } t0_event_t;

endpackage

// ==== logic/pulse_channel.sv ====
// ======================================================================
// single delay/width channel
// registered window compare of the period count against one pair
// ======================================================================

`timescale 1ns/1ps

module pulse_channel
   import dg_pkg::*;
(
   input  logic             clk100,
   input  logic             hps_fpga_reset_n,
   input  logic [CNT_W-1:0] count,                // period count
   input  delay_width_t     setting,              // active delay/width pair
   output logic             pulse                 // high inside the window
);

   logic [CNT_W:0] win_end;                       // one extra bit, no wrap
   logic           after_start;
   logic           before_end;

   // window is [delay, delay+width)
   assign win_end     = {1'b0, setting.delay} + {1'b0, setting.width};
   assign after_start = (count >= setting.delay);
   assign before_end  = ({1'b0, count} < win_end);   // width 0 never true here

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pulse <= 1'b0;
      end else begin
         pulse <= after_start && before_end;
      end
   end

endmodule

// ==== logic/setpoint_regs.sv ====
// ======================================================================
// host setpoint registers
// decodes single-cycle host writes into interval, staged pairs and
// protocol; clamps the interval and commits staged pairs on request
// ======================================================================

`timescale 1ns/1ps

module setpoint_regs
   import dg_pkg::*;
(
   input  logic               clk100,
   input  logic               hps_fpga_reset_n,   // sync, active low
   input  host_write_t        host,               // host write port
   output logic [CNT_W-1:0]   interval,           // clamped repetition interval
   output channel_set_t       channels,           // active pair set
   output logic [PROTO_W-1:0] protocol            // current protocol number
);

   logic                    wr_ctrl;              // ctrl register hit
   logic                    wr_proto;             // protocol register hit
   logic [NDELAY_PAIRS-1:0] wr_pair;              // one-hot pair register hit
   logic [CNT_W-1:0]        wr_interval;          // clamped write value
   channel_set_t            staged;               // written but not yet active

   // ===================================================================
   // address decode
   // ===================================================================
   assign wr_ctrl  = host.wr && (host.addr == ADDR_CTRL);
   assign wr_proto = host.wr && (host.addr == ADDR_PROTO);

   for (genvar k = 0; k < NDELAY_PAIRS; k++) begin : g_pair_dec
      assign wr_pair[k] = host.wr && (host.addr == ADDR_W'(ADDR_PAIR0 + k));
   end

   // short intervals rounded up to the floor
   assign wr_interval = (host.data[CNT_W-1:0] < INTERVAL_MIN) ? INTERVAL_MIN
                                                              : host.data[CNT_W-1:0];

   // ===================================================================
   // registers
   // ===================================================================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         staged <= '0;                             // all pairs cleared
      end else begin
         for (int k = 0; k < NDELAY_PAIRS; k++) begin
            if (wr_pair[k]) begin
               staged[k] <= delay_width_t'(host.data); // delay hi, width lo
            end
         end
      end
   end

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         interval <= INTERVAL_RESET;
         channels <= '0;
      end else if (wr_ctrl) begin
         interval <= wr_interval;
         if (host.data[COMMIT_BIT]) begin
            channels <= staged;                    // whole set moves at once
         end
      end
   end

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         protocol <= '0;
      end else if (wr_proto) begin
         protocol <= host.data[PROTO_W-1:0];
      end
   end

endmodule

// ==== logic/trigger_out_stage.sv ====
// ======================================================================
// trigger output stage
// channel to pin mapping with OR of shared pins, active-low pin
// register, t0 output, 64-bit cycle counter and t0 event capture
// ======================================================================

`timescale 1ns/1ps

module trigger_out_stage
   import dg_pkg::*;
(
   input  logic                    clk100,
   input  logic                    hps_fpga_reset_n,
   input  logic                    t0_raw,
   input  logic [NDELAY_PAIRS-1:0] pulses,
   input  logic [PROTO_W-1:0]      protocol,
   output logic [NDELAY_PINS-1:0]  trig_pins,     // active low
   output logic                    t0,
   output t0_event_t               t0_event
);

   logic [NDELAY_PINS-1:0] pin_level;             // active-high before inversion
   logic [TS_W-1:0]        cycle_cnt;             // cycles since reset release
   logic                   ev_valid;
   logic [TS_W-1:0]        ev_timestamp;
   logic [PROTO_W-1:0]     ev_protocol;

   // ===================================================================
   // pin mapping
   // ===================================================================
   assign pin_level[0] = pulses[0];               // push
   assign pin_level[1] = pulses[1];               // inject
   assign pin_level[2] = pulses[2] | pulses[3];   // ejection pair
   assign pin_level[3] = pulses[4] | pulses[5];   // gate pair
   assign pin_level[4] = pulses[6];               // adc delay
   assign pin_level[5] = pulses[7];
   assign pin_level[6] = pulses[8];

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         trig_pins <= '1;                          // idle high
         t0        <= 1'b0;
         ev_valid  <= 1'b0;
         cycle_cnt <= '0;
      end else begin
         trig_pins <= ~pin_level;
         t0        <= t0_raw;
         ev_valid  <= t0_raw;                      // lines up with t0
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   // event payload, held between t0s
   always_ff @(posedge clk100) begin
      if (t0_raw) begin
         ev_timestamp <= cycle_cnt;
         ev_protocol  <= protocol;
      end
   end

   assign t0_event = '{valid: ev_valid, timestamp: ev_timestamp, protocol: ev_protocol};

endmodule

// ==== verification/dg_cases.txt ====
# interval protocol channel delay width commit, decimal, one case per line
# commit 0 stages the pair without the commit flag and commits one period later
1000 1 0 0 10 1
2500 2 1 100 400 1
500 3 3 20 30 1
1200 0 2 1100 100 1
1500 1 4 7 1 1
1500 2 5 300 0 1
1000 3 6 999 1 1
2000 0 7 50 1950 1
999 1 8 500 250 1
1000 2 1 200 100 0
1800 3 3 1000 800 1

// ==== verification/tb_delay_generator.sv ====
// ======================================================================
// testbench for the delay generator top level
// case file reader, host register writes, t0 waits with timeouts,
// pin window, t0, event record and period compare tasks
// ======================================================================

`timescale 1ns/1ps

module tb_delay_generator
   import dg_pkg::*;
();

   logic                   clk100 = 1'b0;
   logic                   hps_fpga_reset_n;
   host_write_t            host;
   logic [NDELAY_PINS-1:0] trig_pins;
   logic                   t0;
   t0_event_t              t0_event;

   int               errors    = 0;
   int               checks    = 0;
   longint unsigned  cycle     = 0;               // posedges since time 0
   int               act_chan  = 0;               // committed pair as the host sees it
   logic [CNT_W-1:0] act_delay = '0;
   logic [CNT_W-1:0] act_width = '0;

   delay_generator_top DUT (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .host             (host),
      .trig_pins        (trig_pins),
      .t0               (t0),
      .t0_event         (t0_event)
   );

   always #5 clk100 = ~clk100;                    // 10 ns period
   always @(posedge clk100) cycle <= cycle + 1;

   // ===================================================================
   // compare tasks
   // ===================================================================
   task automatic check_pins(input logic [NDELAY_PINS-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s, trig_pins %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_t0(input logic got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s, t0 %b, expected %b", $time, what, got, exp);
      end
   endtask

   // fields 0 valid only, 1 adds protocol, 2 adds timestamp
   task automatic check_event(input t0_event_t got, exp, input int fields, input string what);
      bit bad;
      checks++;
      bad = (got.valid !== exp.valid);
      if (fields >= 1 && got.protocol !== exp.protocol) bad = 1'b1;
      if (fields >= 2 && got.timestamp !== exp.timestamp) bad = 1'b1;
      if (bad) begin
         errors++;
         $display("FAIL %0t: %s, event %b/%0d/%0d, expected %b/%0d/%0d", $time, what,
                  got.valid, got.timestamp, got.protocol, exp.valid, exp.timestamp,
                  exp.protocol);
      end
   endtask

   task automatic check_period(input logic [CNT_W-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s, %0d cycles, expected %0d", $time, what, got, exp);
      end
   endtask

   // ===================================================================
   // expected pin levels
   // ===================================================================
   function automatic int pin_of(input int chan);
      case (chan)
         0, 1:    return chan;
         2, 3:    return 2;                       // shared ejection pin
         4, 5:    return 3;                       // shared gate pin
         default: return chan - 2;                // channels 6..8 on pins 4..6
      endcase
   endfunction

   function automatic logic [NDELAY_PINS-1:0] expected_pins(input int chan,
         input logic [CNT_W-1:0] delay, width, offset);
      logic [NDELAY_PINS-1:0] pins;
      pins = '1;                                  // idle high
      if (offset >= delay && offset - delay < width) begin
         pins[pin_of(chan)] = 1'b0;
      end
      return pins;
   endfunction

   // ===================================================================
   // host writes and t0 waits
   // ===================================================================
   task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [HOST_DATA_W-1:0] data);
      @(posedge clk100);
      #1;
      host.wr   = 1'b1;                           // one-cycle strobe
      host.addr = addr;
      host.data = data;
      @(posedge clk100);
      #1;
      host = '0;
   endtask

   task automatic write_ctrl(input int interval_w, input bit commit);
      logic [HOST_DATA_W-1:0] data;
      data             = '0;
      data[CNT_W-1:0]  = interval_w;
      data[COMMIT_BIT] = commit;
      write_reg(ADDR_CTRL, data);
   endtask

   // clears every staged pair, then loads the chosen one
   task automatic stage_pair(input int chan, input logic [CNT_W-1:0] delay, width);
      for (int k = 0; k < NDELAY_PAIRS; k++) begin
         write_reg(ADDR_W'(ADDR_PAIR0 + k), '0);
      end
      write_reg(ADDR_W'(ADDR_PAIR0 + chan), {delay, width});
   endtask

   task automatic wait_t0(input int limit, output bit found, output longint unsigned at);
      found = 1'b0;
      at    = 0;
      for (int i = 0; i < limit && !found; i++) begin
         @(posedge clk100);
         #1;
         if (t0) begin
            found = 1'b1;
            at    = cycle;
         end
      end
      if (!found) begin
         errors++;
         $display("ERROR at %0t: no t0 pulse seen within %0d cycles", $time, limit);
      end
   endtask

   // one full period: window on every cycle, spacing and both event records
   task automatic run_period(input int idx, input logic [CNT_W-1:0] period, input int chan,
         input logic [CNT_W-1:0] delay, width, input logic [PROTO_W-1:0] proto);
      bit              found;
      longint unsigned t_a;
      longint unsigned t_b;
      t0_event_t       exp_ev;
      wait_t0(period + 16, found, t_a);
      if (!found) return;
      exp_ev = '{valid: 1'b1, timestamp: '0, protocol: proto};
      check_event(t0_event, exp_ev, 1, $sformatf("case %0d first event", idx));
      exp_ev.timestamp = t0_event.timestamp + period;   // next record one interval on
      for (int n = 0; n < period; n++) begin
         if (n != 0) begin
            @(posedge clk100);
            #1;
            check_t0(t0, 1'b0, $sformatf("case %0d offset %0d", idx, n));
            check_event(t0_event, '0, 0, $sformatf("case %0d offset %0d", idx, n));
         end
         check_pins(trig_pins, expected_pins(chan, delay, width, n),
                    $sformatf("case %0d offset %0d", idx, n));
      end
      wait_t0(period + 16, found, t_b);
      if (!found) return;
      check_period(CNT_W'(t_b - t_a), period, $sformatf("case %0d t0 spacing", idx));
      check_event(t0_event, exp_ev, 2, $sformatf("case %0d next event", idx));
   endtask

   task automatic run_case(input int idx, interval_w, proto, chan, delay, width, commit);
      logic [CNT_W-1:0] period;
      bit               found;
      longint unsigned  at;
      period = (interval_w < int'(INTERVAL_MIN)) ? INTERVAL_MIN : CNT_W'(interval_w);
      stage_pair(chan, delay, width);
      write_reg(ADDR_PROTO, HOST_DATA_W'(proto));
      write_ctrl(interval_w, commit != 0);
      wait_t0(period + 16, found, at);            // period in flight may be short
      if (commit != 0) begin
         run_period(idx, period, chan, delay, width, proto);
      end else begin
         run_period(idx, period, act_chan, act_delay, act_width, proto);  // old pair holds
         write_ctrl(interval_w, 1'b1);
         run_period(idx, period, chan, delay, width, proto);
      end
      act_chan  = chan;
      act_delay = delay;
      act_width = width;
   endtask

   // ===================================================================
   // main sequence
   // ===================================================================
   initial begin
      int    fd;
      int    n_cases;
      string line;
      int    c_interval, c_proto, c_chan, c_delay, c_width, c_commit;
      n_cases          = 0;
      hps_fpga_reset_n = 1'b0;
      host             = '0;
      repeat (8) begin
         @(posedge clk100);
         #1;
         check_pins(trig_pins, '1, "pins in reset");
         check_t0(t0, 1'b0, "t0 in reset");
         check_event(t0_event, '0, 0, "event valid in reset");
      end
      hps_fpga_reset_n = 1'b1;
      repeat (16) begin                           // nothing written yet
         @(posedge clk100);
         #1;
         check_pins(trig_pins, '1, "pins before first write");
      end
      fd = $fopen("verification/dg_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("ERROR: the case file verification/dg_cases.txt could not be opened");
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
               break;
            end
            if ($sscanf(line, "%d %d %d %d %d %d", c_interval, c_proto, c_chan, c_delay,
                        c_width, c_commit) == 6) begin   // comment lines give no match
               n_cases++;
               run_case(n_cases, c_interval, c_proto, c_chan, c_delay, c_width, c_commit);
            end
         end
         $fclose(fd);
         if (n_cases == 0) begin
            errors++;
            $display("ERROR: the case file held no usable cases");
         end
      end
      $display("cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
logic/dg_pkg.sv
logic/setpoint_regs.sv
logic/pulse_channel.sv
logic/delay_pulse_core.sv
logic/trigger_out_stage.sv
logic/delay_generator_top.sv
verification/tb_delay_generator.sv
